// ==== logic/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    // datapath widths
    typedef logic [63:0] data_t;
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    localparam int NUM_REGS = 32;

    // memory address widths, word addressed
    localparam int I_ADDR_BITS = 6;
    localparam int D_ADDR_BITS = 6;

    typedef logic [I_ADDR_BITS-1:0] i_addr_t;
    typedef logic [D_ADDR_BITS-1:0] d_addr_t;

    // opcodes of the supported subset
    typedef logic [6:0] opcode_t;

    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_LOAD   = 7'b0000011;

    // instruction class from the control unit
    typedef enum logic [3:0] {
        CMD_R  = 4'b0000,
        CMD_I  = 4'b0001,
        CMD_S  = 4'b0010,
        CMD_SB = 4'b0011,
        CMD_U  = 4'b0100,
        CMD_UJ = 4'b0101
    } alu_cmd_e;

    typedef enum logic [1:0] {
        ALU_ADD = 2'b00,
        ALU_SUB = 2'b01,
        ALU_AND = 2'b10,
        ALU_OR  = 2'b11
    } alu_op_e;

    // flag bit positions
    typedef logic [3:0] flags_t;

    localparam int FLAG_ZERO     = 0;
    localparam int FLAG_NEGATIVE = 1;
    localparam int FLAG_BORROW   = 2;
    localparam int FLAG_OVERFLOW = 3;

endpackage

`default_nettype wire

// ==== logic/instr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
    input  rv_pkg::word_t    i_instr,
    input  rv_pkg::alu_cmd_e i_alu_cmd,
    output rv_pkg::opcode_t  o_opcode,
    output rv_pkg::reg_idx_t o_rs1,
    output rv_pkg::reg_idx_t o_rs2,
    output rv_pkg::reg_idx_t o_rd,
    output rv_pkg::data_t    o_imm,
    output rv_pkg::alu_op_e  o_alu_op
);

    import rv_pkg::*;

    data_t imm_i;
    data_t imm_s;
    data_t imm_b;
    data_t imm_u;
    data_t imm_j;
    logic [3:0] funct;

    // fixed field positions
    assign o_opcode = i_instr[6:0];
    assign o_rd     = i_instr[11:7];
    assign o_rs1    = i_instr[19:15];
    assign o_rs2    = i_instr[24:20];

    // sign-extended immediates, standard bit placement
    assign imm_i = {{52{i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{52{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_b = {{51{i_instr[31]}}, i_instr[31], i_instr[7],
                    i_instr[30:25], i_instr[11:8], 1'b0};
    assign imm_u = {{32{i_instr[31]}}, i_instr[31:12], 12'b0};
    assign imm_j = {{43{i_instr[31]}}, i_instr[31], i_instr[19:12],
                    i_instr[20], i_instr[30:21], 1'b0};

    always_comb begin
        case (o_opcode)
            OP_IMM, OP_JALR, OP_LOAD: o_imm = imm_i;
            OP_STORE:                 o_imm = imm_s;
            OP_BRANCH:                o_imm = imm_b;
            OP_AUIPC:                 o_imm = imm_u;
            OP_JAL:                   o_imm = imm_j;
            // R-type and unknown opcodes carry no immediate
            default:                  o_imm = '0;
        endcase
    end

    // bit 30 separates add from sub
    assign funct = {i_instr[30], i_instr[14:12]};

    always_comb begin
        case (i_alu_cmd)
            CMD_R: begin
                case (funct)
                    4'b0000: o_alu_op = ALU_ADD;
                    4'b1000: o_alu_op = ALU_SUB;
                    4'b0111: o_alu_op = ALU_AND;
                    4'b0110: o_alu_op = ALU_OR;
                    default: o_alu_op = ALU_ADD;
                endcase
            end
            // branch compare
            CMD_SB:  o_alu_op = ALU_SUB;
            default: o_alu_op = ALU_ADD;
        endcase
    end

    a_known_cmd: assert final ($isunknown(i_alu_cmd) ||
                               i_alu_cmd inside {CMD_R, CMD_I, CMD_S,
                                                 CMD_SB, CMD_U, CMD_UJ})
        else $error("instr_decode: undefined alu_cmd %b", i_alu_cmd);

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire              clk,
    input  wire              reset,
    input  rv_pkg::reg_idx_t i_rs1,
    input  rv_pkg::reg_idx_t i_rs2,
    input  rv_pkg::reg_idx_t i_rd,
    input  wire              i_we,
    input  wire              i_rf_src,
    input  rv_pkg::data_t    i_alu_result,
    input  rv_pkg::data_t    i_load_data,
    output rv_pkg::data_t    o_rs1_data,
    output rv_pkg::data_t    o_rs2_data
);

    import rv_pkg::*;

    // x0 cleared at reset, never written after
    data_t regs [NUM_REGS];
    data_t wb_data;

    // write-back source: 0 alu, 1 load data
    assign wb_data = i_rf_src ? i_load_data : i_alu_result;

    always_ff @(posedge clk) begin
        if (!reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_rd != '0)) begin
            regs[i_rd] <= wb_data;
        end
    end

    // combinational read ports
    assign o_rs1_data = regs[i_rs1];
    assign o_rs2_data = regs[i_rs2];

    // the write guard keeps x0 at zero
    a_x0_not_stored: assert property (
        @(posedge clk) disable iff (!reset)
        regs[0] == '0
    ) else $error("reg_file: x0 holds a nonzero value");

endmodule

`default_nettype wire

// ==== logic/alu_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_execute (
    input  rv_pkg::data_t   i_a,
    input  rv_pkg::data_t   i_rs2_data,
    input  rv_pkg::data_t   i_imm,
    input  wire             i_alu_src,
    input  rv_pkg::alu_op_e i_alu_op,
    output rv_pkg::data_t   o_result,
    output rv_pkg::flags_t  o_flags
);

    import rv_pkg::*;

    data_t       b_operand;
    data_t       b_adder;
    logic        is_sub;
    logic        is_arith;
    logic [64:0] sum;

    // operand b: 0 rs2, 1 immediate
    assign b_operand = i_alu_src ? i_imm : i_rs2_data;

    assign is_sub   = (i_alu_op == ALU_SUB);
    assign is_arith = (i_alu_op == ALU_ADD) || is_sub;

    // sub as a + ~b + 1 on one 65-bit adder
    assign b_adder = is_sub ? ~b_operand : b_operand;
    assign sum     = {1'b0, i_a} + {1'b0, b_adder} + {64'b0, is_sub};

    always_comb begin
        case (i_alu_op)
            ALU_AND: o_result = i_a & b_operand;
            ALU_OR:  o_result = i_a | b_operand;
            default: o_result = sum[63:0];
        endcase
    end

    assign o_flags[FLAG_ZERO]     = ~|o_result;
    assign o_flags[FLAG_NEGATIVE] = o_result[63];
    // no carry out means borrow
    assign o_flags[FLAG_BORROW]   = is_arith & ~sum[64];
    // same input signs, different result sign
    assign o_flags[FLAG_OVERFLOW] = is_arith &
                                    (i_a[63] == b_adder[63]) &
                                    (sum[63] != i_a[63]);

    // on a compare the zero flag means equal operands
    a_sub_zero: assert final ($isunknown({i_a, b_operand, i_alu_op}) ||
                              !is_sub ||
                              (o_flags[FLAG_ZERO] == (i_a == b_operand)))
        else $error("alu_execute: zero flag disagrees with a == b");

endmodule

`default_nettype wire

// ==== logic/pc_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module pc_unit (
    input  wire             clk,
    input  wire             reset,
    input  rv_pkg::data_t   i_imm,
    input  wire             i_pc_src,
    output rv_pkg::i_addr_t o_i_mem_addr
);

    import rv_pkg::*;

    word_t pc_q;
    word_t pc_plus4;
    word_t pc_plus_imm;
    word_t pc_next;

    assign pc_plus4    = pc_q + 32'd4;
    // pc is 32 bits, upper immediate bits dropped
    assign pc_plus_imm = pc_q + i_imm[31:0];
    assign pc_next     = i_pc_src ? pc_plus_imm : pc_plus4;

    always_ff @(posedge clk) begin
        if (!reset) begin
            pc_q <= '0;
        end else begin
            pc_q <= pc_next;
        end
    end

    // word address into instruction memory
    assign o_i_mem_addr = pc_q[I_ADDR_BITS+1:2];

    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!reset)
        !i_pc_src |=> (pc_q[1:0] == $past(pc_q[1:0]))
    ) else $error("pc_unit: sequential step changed pc alignment");

endmodule

`default_nettype wire

// ==== logic/rv_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_datapath (
    input  wire              clk,
    input  wire              reset,
    input  rv_pkg::word_t    i_i_mem_data,
    input  wire              i_rf_we,
    input  wire              i_d_mem_we,
    input  rv_pkg::alu_cmd_e i_alu_cmd,
    input  wire              i_alu_src,
    input  wire              i_pc_src,
    input  wire              i_rf_src,
    input  rv_pkg::data_t    i_d_mem_rdata,
    output rv_pkg::opcode_t  o_opcode,
    output rv_pkg::flags_t   o_alu_flags,
    output rv_pkg::i_addr_t  o_i_mem_addr,
    output rv_pkg::d_addr_t  o_d_mem_addr,
    output rv_pkg::data_t    o_d_mem_wdata,
    output wire              o_d_mem_we
);

    import rv_pkg::*;

    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    data_t    imm;
    alu_op_e  alu_op;
    data_t    rs1_data;
    data_t    rs2_data;
    data_t    alu_result;

    instr_decode u_decode (
        .i_instr   (i_i_mem_data),
        .i_alu_cmd (i_alu_cmd),
        .o_opcode  (o_opcode),
        .o_rs1     (rs1),
        .o_rs2     (rs2),
        .o_rd      (rd),
        .o_imm     (imm),
        .o_alu_op  (alu_op)
    );

    reg_file u_reg_file (
        .clk          (clk),
        .reset        (reset),
        .i_rs1        (rs1),
        .i_rs2        (rs2),
        .i_rd         (rd),
        .i_we         (i_rf_we),
        .i_rf_src     (i_rf_src),
        .i_alu_result (alu_result),
        .i_load_data  (i_d_mem_rdata),
        .o_rs1_data   (rs1_data),
        .o_rs2_data   (rs2_data)
    );

    alu_execute u_alu (
        .i_a        (rs1_data),
        .i_rs2_data (rs2_data),
        .i_imm      (imm),
        .i_alu_src  (i_alu_src),
        .i_alu_op   (alu_op),
        .o_result   (alu_result),
        .o_flags    (o_alu_flags)
    );

    pc_unit u_pc (
        .clk          (clk),
        .reset        (reset),
        .i_imm        (imm),
        .i_pc_src     (i_pc_src),
        .o_i_mem_addr (o_i_mem_addr)
    );

    // data memory side
    assign o_d_mem_addr  = alu_result[D_ADDR_BITS-1:0];
    assign o_d_mem_wdata = rs2_data;
    assign o_d_mem_we    = i_d_mem_we;

endmodule

`default_nettype wire

// ==== tb/tb_rv_model.svh ====
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

// reference state, stepped at every clock edge
word_t model_pc;
data_t model_regs [32];

function automatic data_t model_read(reg_idx_t idx);
    if (idx == 5'd0) begin
        return '0;
    end
    return model_regs[idx];
endfunction

// immediate fields moved to the top, then shifted back down with sign
function automatic data_t model_imm(word_t ins);
    logic signed [31:0] v;
    v = '0;
    case (ins[6:0])
        OP_IMM, OP_JALR, OP_LOAD: v = $signed(ins) >>> 20;
        OP_STORE:  v = $signed({ins[31:25], ins[11:7], 20'b0}) >>> 20;
        OP_BRANCH: v = $signed({ins[31], ins[7], ins[30:25], ins[11:8], 20'b0}) >>> 19;
        OP_AUIPC:  v = {ins[31:12], 12'b0};
        OP_JAL:    v = $signed({ins[31], ins[19:12], ins[20], ins[30:21], 12'b0}) >>> 11;
        default:   v = '0;
    endcase
    return {{32{v[31]}}, v};
endfunction

function automatic alu_op_e model_alu_op(word_t ins, alu_cmd_e cmd);
    if (cmd == CMD_SB) begin
        return ALU_SUB;
    end
    if (cmd != CMD_R) begin
        return ALU_ADD;
    end
    case ({ins[30], ins[14:12]})
        4'b1000: return ALU_SUB;
        4'b0111: return ALU_AND;
        4'b0110: return ALU_OR;
        default: return ALU_ADD;
    endcase
endfunction

function automatic void model_alu(input data_t a, input data_t b, input alu_op_e op,
                                  output data_t res, output flags_t flags);
    logic [64:0] wide;
    logic        borrow;
    logic        ovf;
    borrow = 1'b0;
    ovf    = 1'b0;
    case (op)
        ALU_ADD: begin
            wide   = {1'b0, a} + {1'b0, b};
            res    = wide[63:0];
            borrow = !wide[64];
            ovf    = (a[63] == b[63]) && (res[63] != a[63]);
        end
        ALU_SUB: begin
            res    = a - b;
            // unsigned a below b leaves no carry
            borrow = (a < b);
            ovf    = (a[63] != b[63]) && (res[63] != a[63]);
        end
        ALU_AND: res = a & b;
        default: res = a | b;
    endcase
    flags = {ovf, borrow, res[63], (res == 64'd0)};
endfunction

function automatic void model_eval(input word_t ins, input alu_cmd_e cmd, input logic asrc,
                                   output data_t res, output flags_t flags);
    data_t b;
    b = asrc ? model_imm(ins) : model_read(ins[24:20]);
    model_alu(model_read(ins[19:15]), b, model_alu_op(ins, cmd), res, flags);
endfunction

function automatic void model_clear();
    model_pc = '0;
    for (int i = 0; i < 32; i++) begin
        model_regs[i] = '0;
    end
endfunction

function automatic void model_step(word_t ins, alu_cmd_e cmd, logic asrc, logic psrc,
                                   logic we, logic rsrc, data_t load_data);
    data_t  res;
    flags_t flags;
    data_t  imm;
    model_eval(ins, cmd, asrc, res, flags);
    imm = model_imm(ins);
    if (we && (ins[11:7] != 5'd0)) begin
        model_regs[ins[11:7]] = rsrc ? load_data : res;
    end
    model_pc = psrc ? (model_pc + imm[31:0]) : (model_pc + 32'd4);
endfunction

`endif

// ==== tb/tb_rv_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rv_datapath;

    import rv_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DELAY = 2;
    localparam int RESET_LIMIT = 20;
    localparam int RANDOM_OPS  = 400;

    logic     clk;
    logic     reset;
    word_t    instr;
    logic     rf_we;
    logic     d_mem_we;
    alu_cmd_e alu_cmd;
    logic     alu_src;
    logic     pc_src;
    logic     rf_src;
    data_t    rdata;
    opcode_t  opcode;
    flags_t   alu_flags;
    i_addr_t  i_mem_addr;
    d_addr_t  d_mem_addr;
    data_t    d_mem_wdata;
    logic     d_mem_we_out;

    integer seed;
    string  cur_test;
    int     n_checks;
    int     n_errors;
    int     n_tests;
    int     errors_at_start;

    `include "tb_rv_model.svh"

    rv_datapath i_dut (
        .clk           (clk),
        .reset         (reset),
        .i_i_mem_data  (instr),
        .i_rf_we       (rf_we),
        .i_d_mem_we    (d_mem_we),
        .i_alu_cmd     (alu_cmd),
        .i_alu_src     (alu_src),
        .i_pc_src      (pc_src),
        .i_rf_src      (rf_src),
        .i_d_mem_rdata (rdata),
        .o_opcode      (opcode),
        .o_alu_flags   (alu_flags),
        .o_i_mem_addr  (i_mem_addr),
        .o_d_mem_addr  (d_mem_addr),
        .o_d_mem_wdata (d_mem_wdata),
        .o_d_mem_we    (d_mem_we_out)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        reset = 1'b0;
        repeat (5) @(posedge clk);
        #DRIVE_DELAY reset = 1'b1;
    end

    // model follows the DUT edge by edge
    always @(posedge clk) begin
        if (!reset) begin
            model_clear();
        end else begin
            model_step(instr, alu_cmd, alu_src, pc_src, rf_we, rf_src, rdata);
        end
    end

    task automatic check_data(string what, data_t exp, data_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("FAIL %s %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_flags(string what, flags_t exp, flags_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("FAIL %s %s: expected %b, actual %b", cur_test, what, exp, act);
        end
    endtask

    task automatic check_addr(string what, i_addr_t exp, i_addr_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("FAIL %s %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_opcode(string what, opcode_t exp, opcode_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("FAIL %s %s: expected %b, actual %b", cur_test, what, exp, act);
        end
    endtask

    task automatic check_bit(string what, logic exp, logic act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("FAIL %s %s: expected %b, actual %b", cur_test, what, exp, act);
        end
    endtask

    task automatic start_test(string name);
        cur_test        = name;
        errors_at_start = n_errors;
    endtask

    task automatic end_test();
        n_tests++;
        if (n_errors == errors_at_start) begin
            $display("test %s: ok", cur_test);
        end else begin
            $display("test %s: %0d mismatches", cur_test, n_errors - errors_at_start);
        end
    endtask

    // called 2 ns after a rising edge, returns 2 ns after the next one
    task automatic run_instr(word_t ins, logic we, logic dwe, alu_cmd_e cmd,
                             logic asrc, logic psrc, logic rsrc);
        data_t  exp_res;
        flags_t exp_flags;
        instr    = ins;
        rf_we    = we;
        d_mem_we = dwe;
        alu_cmd  = cmd;
        alu_src  = asrc;
        pc_src   = psrc;
        rf_src   = rsrc;
        rdata    = {$random(seed), $random(seed)};
        #(CLK_PERIOD / 2);
        model_eval(ins, cmd, asrc, exp_res, exp_flags);
        check_opcode("opcode", ins[6:0], opcode);
        check_addr("i_mem_addr", model_pc[I_ADDR_BITS+1:2], i_mem_addr);
        check_addr("d_mem_addr", exp_res[D_ADDR_BITS-1:0], d_mem_addr);
        check_data("d_mem_wdata", model_read(ins[24:20]), d_mem_wdata);
        check_bit("d_mem_we", dwe, d_mem_we_out);
        check_flags("alu_flags", exp_flags, alu_flags);
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic random_instr();
        word_t      ins;
        int         kind;
        logic [1:0] pick;
        ins  = $random(seed);
        kind = {$random(seed)} % 8;
        pick = $random(seed);
        case (kind)
            0: begin
                ins[6:0] = OP_REG;
                case (pick)
                    2'd0: {ins[30], ins[14:12]} = 4'b0000;
                    2'd1: {ins[30], ins[14:12]} = 4'b1000;
                    2'd2: {ins[30], ins[14:12]} = 4'b0111;
                    default: {ins[30], ins[14:12]} = 4'b0110;
                endcase
                run_instr(ins, 1'b1, 1'b0, CMD_R, 1'b0, 1'b0, 1'b0);
            end
            1: begin
                ins[6:0] = OP_IMM;
                run_instr(ins, 1'b1, 1'b0, CMD_I, 1'b1, 1'b0, 1'b0);
            end
            2: begin
                ins[6:0] = OP_LOAD;
                run_instr(ins, 1'b1, 1'b0, CMD_I, 1'b1, 1'b0, 1'b1);
            end
            3: begin
                ins[6:0] = OP_STORE;
                run_instr(ins, 1'b0, 1'b1, CMD_S, 1'b1, 1'b0, 1'b0);
            end
            4: begin
                ins[6:0] = OP_BRANCH;
                run_instr(ins, 1'b0, 1'b0, CMD_SB, 1'b0, pick[0], 1'b0);
            end
            5: begin
                ins[6:0] = OP_AUIPC;
                run_instr(ins, 1'b1, 1'b0, CMD_U, 1'b1, 1'b0, 1'b0);
            end
            6: begin
                ins[6:0] = OP_JAL;
                run_instr(ins, 1'b0, 1'b0, CMD_UJ, 1'b1, 1'b1, 1'b0);
            end
            default: begin
                ins[6:0] = OP_JALR;
                run_instr(ins, 1'b0, 1'b0, CMD_I, 1'b1, 1'b1, 1'b0);
            end
        endcase
    endtask

    initial begin
        int    cycles;
        word_t ins;
        seed     = 68714;
        n_checks = 0;
        n_errors = 0;
        n_tests  = 0;
        instr    = '0;
        rf_we    = 1'b0;
        d_mem_we = 1'b0;
        alu_cmd  = CMD_I;
        alu_src  = 1'b0;
        pc_src   = 1'b0;
        rf_src   = 1'b0;
        rdata    = '0;

        start_test("reset_state");
        cycles = 0;
        while ((reset !== 1'b1) && (cycles < RESET_LIMIT)) begin
            @(negedge clk);
            cycles++;
        end
        if (reset !== 1'b1) begin
            $display("reset was not released within %0d cycles", RESET_LIMIT);
            $display("TB FAILED");
            $finish;
        end
        check_addr("i_mem_addr", '0, i_mem_addr);
        end_test();
        @(posedge clk);
        #DRIVE_DELAY;

        // every register read through the store path
        start_test("zero_regs");
        for (int k = 0; k < 32; k++) begin
            ins        = $random(seed);
            ins[6:0]   = OP_STORE;
            ins[19:15] = k;
            ins[24:20] = k;
            run_instr(ins, 1'b0, 1'b1, CMD_S, 1'b1, 1'b0, 1'b0);
        end
        end_test();

        start_test("x0_write");
        for (int k = 0; k < 8; k++) begin
            ins        = $random(seed);
            ins[6:0]   = OP_IMM;
            ins[11:7]  = 5'd0;
            run_instr(ins, 1'b1, 1'b0, CMD_I, 1'b1, 1'b0, 1'b0);
            ins        = $random(seed);
            ins[6:0]   = OP_STORE;
            ins[24:20] = 5'd0;
            run_instr(ins, 1'b0, 1'b1, CMD_S, 1'b1, 1'b0, 1'b0);
        end
        end_test();

        start_test("random_mix");
        for (int k = 0; k < RANDOM_OPS; k++) begin
            random_instr();
        end
        end_test();

        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+tb
logic/rv_pkg.sv
logic/instr_decode.sv
logic/reg_file.sv
logic/alu_execute.sv
logic/pc_unit.sv
logic/rv_datapath.sv
tb/tb_rv_datapath.sv
